//--- common/nano_wb_cfg.svh
`ifndef NANO_WB_CFG_SVH
`define NANO_WB_CFG_SVH

// width of one architectural register and of a result
`define NANO_WB_XLEN 32

// architectural register count, x0 included
`define NANO_WB_NREGS 32

// reorder buffer slots
// a power of two lets the tags wrap on their own
`define NANO_WB_ROB_DEPTH 16

`endif

//--- common/nano_wb_rob_pkg.sv
`include "nano_wb_cfg.svh"

package nano_wb_rob_pkg;

  import nano_wb_types_pkg::*;

  // slot index that goes to the issue side as the tag
  typedef logic [$clog2(`NANO_WB_ROB_DEPTH)-1:0] rob_tag_t;

  // one extra bit so a full buffer can be told apart from an empty one
  typedef logic [$clog2(`NANO_WB_ROB_DEPTH):0] rob_cnt_t;

  typedef struct packed {
    logic     valid;
    logic     done;
    reg_idx_t rd;
    xdata_t   data;
  } rob_entry_t;

  typedef enum logic [1:0] {
    RUN,
    DRAIN,
    DONE
  } fence_state_t;

endpackage

//--- common/nano_wb_types_pkg.sv
`include "nano_wb_cfg.svh"

package nano_wb_types_pkg;

  // one register value or execution result
  typedef logic [`NANO_WB_XLEN-1:0] xdata_t;

  // architectural register index
  typedef logic [$clog2(`NANO_WB_NREGS)-1:0] reg_idx_t;

endpackage

//--- rob/rob_entry_buffer.sv
`timescale 1ns/1ns

`include "nano_wb_cfg.svh"

module rob_entry_buffer (
  input  logic                        clk,
  input  logic                        resetn,
  // allocation at the tail
  input  logic                        alloc_i,
  input  nano_wb_rob_pkg::rob_tag_t   alloc_tag_i,
  input  nano_wb_types_pkg::reg_idx_t alloc_rd_i,
  // completions in any order
  input  logic                        cpl0_valid_i,
  input  nano_wb_rob_pkg::rob_tag_t   cpl0_tag_i,
  input  nano_wb_types_pkg::xdata_t   cpl0_data_i,
  input  logic                        cpl1_valid_i,
  input  nano_wb_rob_pkg::rob_tag_t   cpl1_tag_i,
  input  nano_wb_types_pkg::xdata_t   cpl1_data_i,
  // retirement at the head
  input  logic                        retire_i,
  input  nano_wb_rob_pkg::rob_tag_t   head_i,
  output logic                        head_done_o,
  output nano_wb_types_pkg::reg_idx_t head_rd_o,
  output nano_wb_types_pkg::xdata_t   head_data_o
);

  import nano_wb_rob_pkg::*;

  rob_entry_t slots [`NANO_WB_ROB_DEPTH];

  // reset empties every slot
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      for (int i = 0; i < `NANO_WB_ROB_DEPTH; i++) begin
        slots[i].valid <= 1'b0;
        slots[i].done  <= 1'b0;
      end
    end else begin
      if (alloc_i) begin
        slots[alloc_tag_i].valid <= 1'b1;
        slots[alloc_tag_i].done  <= 1'b0;
        slots[alloc_tag_i].rd    <= alloc_rd_i;
      end
      // the two ports never carry the same tag in one cycle
      if (cpl0_valid_i) begin
        slots[cpl0_tag_i].done <= 1'b1;
        slots[cpl0_tag_i].data <= cpl0_data_i;
      end
      if (cpl1_valid_i) begin
        slots[cpl1_tag_i].done <= 1'b1;
        slots[cpl1_tag_i].data <= cpl1_data_i;
      end
      // the head slot is never the one being allocated
      if (retire_i) begin
        slots[head_i].valid <= 1'b0;
      end
    end
  end

  // head readout straight from the slot registers
  assign head_done_o = slots[head_i].valid & slots[head_i].done;
  assign head_rd_o   = slots[head_i].rd;
  assign head_data_o = slots[head_i].data;

endmodule

//--- rob/rob_ptr_counter.sv
`timescale 1ns/1ns

`include "nano_wb_cfg.svh"

module rob_ptr_counter (
  input  logic                      clk,
  input  logic                      resetn,
  input  logic                      alloc_i,
  input  logic                      retire_i,
  output nano_wb_rob_pkg::rob_tag_t tail_o,
  output nano_wb_rob_pkg::rob_tag_t head_o,
  output logic                      full_o,
  output logic                      empty_o
);

  import nano_wb_rob_pkg::*;

  rob_tag_t tail_q;
  rob_tag_t head_q;
  rob_cnt_t count_q;

  // pointers wrap naturally since the depth is a power of two
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      tail_q  <= '0;
      head_q  <= '0;
      count_q <= '0;
    end else begin
      if (alloc_i) begin
        tail_q <= tail_q + rob_tag_t'(1);
      end
      if (retire_i) begin
        head_q <= head_q + rob_tag_t'(1);
      end
      // simultaneous allocate and retire leaves the count alone
      case ({alloc_i, retire_i})
        2'b10:   count_q <= count_q + rob_cnt_t'(1);
        2'b01:   count_q <= count_q - rob_cnt_t'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  assign tail_o  = tail_q;
  assign head_o  = head_q;
  assign full_o  = (count_q == rob_cnt_t'(`NANO_WB_ROB_DEPTH));
  assign empty_o = (count_q == '0);

endmodule

//--- run_sim.sh
#!/bin/sh
# compile and run the nano_wb_core testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -f src.f --top-module tb_nano_wb_core -o sim_tb
# the log decides the result, so a failing run must not stop the script here
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "ERRORS FOUND" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
exit 0

//--- source/fence_ctrl_fsm.sv
`timescale 1ns/1ns

module fence_ctrl_fsm (
  input  logic clk,
  input  logic resetn,
  input  logic fence_i,
  input  logic full_i,
  input  logic empty_i,
  output logic alloc_ready_o,
  output logic fence_done_o
);

  import nano_wb_rob_pkg::*;

  fence_state_t state_q;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state_q <= RUN;
    end else begin
      case (state_q)
        RUN:     if (fence_i) state_q <= DRAIN;
        // wait for the last outstanding entry to retire
        DRAIN:   if (empty_i) state_q <= DONE;
        DONE:    state_q <= RUN;
        default: state_q <= RUN;
      endcase
    end
  end

  // no new entries while a fence is draining
  assign alloc_ready_o = (state_q == RUN) & ~full_i;
  assign fence_done_o  = (state_q == DONE);

endmodule

//--- source/nano_wb_core.sv
`timescale 1ns/1ns

module nano_wb_core (
  input  logic                          clk,
  input  logic                          resetn,
  // issue side
  input  logic                          alloc_valid_i,
  input  nano_wb_types_pkg::reg_idx_t   alloc_rd_i,
  output logic                          alloc_ready_o,
  output nano_wb_rob_pkg::rob_tag_t     alloc_tag_o,
  // completion ports that are always accepted
  input  logic                          cpl0_valid_i,
  input  nano_wb_rob_pkg::rob_tag_t     cpl0_tag_i,
  input  nano_wb_types_pkg::xdata_t     cpl0_data_i,
  input  logic                          cpl1_valid_i,
  input  nano_wb_rob_pkg::rob_tag_t     cpl1_tag_i,
  input  nano_wb_types_pkg::xdata_t     cpl1_data_i,
  // in-order retirement
  input  logic                          retire_ready_i,
  output logic                          retire_valid_o,
  output nano_wb_types_pkg::reg_idx_t   retire_rd_o,
  output nano_wb_types_pkg::xdata_t     retire_data_o,
  // fence
  input  logic                          fence_i,
  output logic                          fence_done_o,
  // committed register reads
  input  nano_wb_types_pkg::reg_idx_t   rs1_addr_i,
  input  nano_wb_types_pkg::reg_idx_t   rs2_addr_i,
  output nano_wb_types_pkg::xdata_t     rs1_data_o,
  output nano_wb_types_pkg::xdata_t     rs2_data_o
);

  import nano_wb_rob_pkg::*;

  logic     alloc_fire;
  logic     retire_fire;
  logic     rob_full;
  logic     rob_empty;
  rob_tag_t head_tag;

  assign alloc_fire  = alloc_valid_i & alloc_ready_o;
  assign retire_fire = retire_valid_o & retire_ready_i;

  fence_ctrl_fsm u_fence_ctrl_fsm (
    .clk           (clk          ),
    .resetn        (resetn       ),
    .fence_i       (fence_i      ),
    .full_i        (rob_full     ),
    .empty_i       (rob_empty    ),
    .alloc_ready_o (alloc_ready_o),
    .fence_done_o  (fence_done_o )
  );

  // the tail pointer is the tag of the next allocation
  rob_ptr_counter u_rob_ptr_counter (
    .clk      (clk        ),
    .resetn   (resetn     ),
    .alloc_i  (alloc_fire ),
    .retire_i (retire_fire),
    .tail_o   (alloc_tag_o),
    .head_o   (head_tag   ),
    .full_o   (rob_full   ),
    .empty_o  (rob_empty  )
  );

  rob_entry_buffer u_rob_entry_buffer (
    .clk          (clk           ),
    .resetn       (resetn        ),
    .alloc_i      (alloc_fire    ),
    .alloc_tag_i  (alloc_tag_o   ),
    .alloc_rd_i   (alloc_rd_i    ),
    .cpl0_valid_i (cpl0_valid_i  ),
    .cpl0_tag_i   (cpl0_tag_i    ),
    .cpl0_data_i  (cpl0_data_i   ),
    .cpl1_valid_i (cpl1_valid_i  ),
    .cpl1_tag_i   (cpl1_tag_i    ),
    .cpl1_data_i  (cpl1_data_i   ),
    .retire_i     (retire_fire   ),
    .head_i       (head_tag      ),
    .head_done_o  (retire_valid_o),
    .head_rd_o    (retire_rd_o   ),
    .head_data_o  (retire_data_o )
  );

  // x0 filtering happens inside the register file
  reg_file u_reg_file (
    .clk      (clk          ),
    .we_i     (retire_fire  ),
    .waddr_i  (retire_rd_o  ),
    .wdata_i  (retire_data_o),
    .raddr1_i (rs1_addr_i   ),
    .raddr2_i (rs2_addr_i   ),
    .rdata1_o (rs1_data_o   ),
    .rdata2_o (rs2_data_o   )
  );

endmodule

//--- source/reg_file.sv
`timescale 1ns/1ns

`include "nano_wb_cfg.svh"

module reg_file (
  input  logic                        clk,
  input  logic                        we_i,
  input  nano_wb_types_pkg::reg_idx_t waddr_i,
  input  nano_wb_types_pkg::xdata_t   wdata_i,
  input  nano_wb_types_pkg::reg_idx_t raddr1_i,
  input  nano_wb_types_pkg::reg_idx_t raddr2_i,
  output nano_wb_types_pkg::xdata_t   rdata1_o,
  output nano_wb_types_pkg::xdata_t   rdata2_o
);

  import nano_wb_types_pkg::*;

  // x0 has no storage
  xdata_t regs [1:`NANO_WB_NREGS-1];

  always_ff @(posedge clk) begin
    if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // reads see committed state only and forward nothing in flight
  assign rdata1_o = (raddr1_i == '0) ? {`NANO_WB_XLEN{1'b0}} : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? {`NANO_WB_XLEN{1'b0}} : regs[raddr2_i];

endmodule

//--- src.f
+incdir+common
common/nano_wb_types_pkg.sv
common/nano_wb_rob_pkg.sv
source/fence_ctrl_fsm.sv
source/reg_file.sv
rob/rob_ptr_counter.sv
rob/rob_entry_buffer.sv
source/nano_wb_core.sv
verification/tb_clk_gen.sv
verification/tb_nano_wb_core.sv

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk,
  output logic resetn
);

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // reset stays low over the first five rising edges and lifts just after the fifth
  initial begin
    resetn = 1'b0;
    repeat (5) @(posedge clk);
    #2 resetn = 1'b1;
  end

endmodule

//--- verification/tb_nano_wb_core.sv
`timescale 1ns/1ns

`include "nano_wb_cfg.svh"

module tb_nano_wb_core;

  import nano_wb_types_pkg::*;
  import nano_wb_rob_pkg::*;

  localparam int DEPTH          = `NANO_WB_ROB_DEPTH;
  localparam int RAND_CYCLES    = 400;
  localparam int BP_CYCLES      = 40;
  localparam int FENCE_CYCLES   = 400;
  localparam int DRAIN_CYCLES   = 64;
  localparam int TIMEOUT_CYCLES =
    (RAND_CYCLES + BP_CYCLES + FENCE_CYCLES + 3 * DRAIN_CYCLES) * 4;

  logic     clk;
  logic     resetn;
  logic     alloc_valid_i;
  reg_idx_t alloc_rd_i;
  logic     alloc_ready_o;
  rob_tag_t alloc_tag_o;
  logic     cpl0_valid_i;
  rob_tag_t cpl0_tag_i;
  xdata_t   cpl0_data_i;
  logic     cpl1_valid_i;
  rob_tag_t cpl1_tag_i;
  xdata_t   cpl1_data_i;
  logic     retire_ready_i;
  logic     retire_valid_o;
  reg_idx_t retire_rd_o;
  xdata_t   retire_data_o;
  logic     fence_i;
  logic     fence_done_o;
  reg_idx_t rs1_addr_i;
  reg_idx_t rs2_addr_i;
  xdata_t   rs1_data_o;
  xdata_t   rs2_data_o;

  // reference model of the in-flight entries in allocation order
  rob_tag_t     q_tag[$];
  reg_idx_t     q_rd[$];
  xdata_t       q_data[$];
  rob_tag_t     pend[$];
  logic         done_m [DEPTH];
  xdata_t       plan_data [DEPTH];
  xdata_t       model_regs [32];
  logic         reg_known [32];
  rob_tag_t     next_tag;
  fence_state_t fstate;
  reg_idx_t     chk_rd;
  logic         chk_en;

  int seed = 32'h0df6_dfdc;
  int alloc_pct;
  int ready_pct;
  int cpl_pct;
  int fence_permille;
  int fence_req_cnt;
  int fence_done_cnt;
  int cycle_cnt = 0;

  tb_clk_gen u_tb_clk_gen (
    .clk    (clk   ),
    .resetn (resetn)
  );

  nano_wb_core u_nano_wb_core (.*);

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
      $display("ERRORS FOUND");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed) & 32'h7fff_ffff;
    return r % n;
  endfunction

  task automatic set_rates(input int a, input int r, input int c, input int f);
    alloc_pct      = a;
    ready_pct      = r;
    cpl_pct        = c;
    fence_permille = f;
  endtask

  task automatic drive_inputs();
    int idx;
    alloc_valid_i  = (rand_below(100) < alloc_pct);
    alloc_rd_i     = reg_idx_t'(rand_below(32));
    retire_ready_i = (rand_below(100) < ready_pct);
    fence_i        = (fstate == RUN) && (rand_below(1000) < fence_permille);
    cpl0_valid_i   = 1'b0;
    cpl1_valid_i   = 1'b0;
    // random pending tags make completions come back out of order
    if (pend.size() > 0 && rand_below(100) < cpl_pct) begin
      idx          = rand_below(pend.size());
      cpl0_valid_i = 1'b1;
      cpl0_tag_i   = pend[idx];
      cpl0_data_i  = plan_data[pend[idx]];
      pend.delete(idx);
    end
    if (pend.size() > 0 && rand_below(100) < cpl_pct) begin
      idx          = rand_below(pend.size());
      cpl1_valid_i = 1'b1;
      cpl1_tag_i   = pend[idx];
      cpl1_data_i  = plan_data[pend[idx]];
      pend.delete(idx);
    end
    // read back the register retired on the last edge
    rs1_addr_i = chk_en ? chk_rd : reg_idx_t'(rand_below(32));
    rs2_addr_i = reg_idx_t'(rand_below(32));
  endtask

  // compare against the model and then apply what the coming edge does
  task automatic sample_outputs();
    logic exp_valid;
    logic exp_ready;
    exp_valid = (q_tag.size() > 0) && done_m[q_tag[0]];
    exp_ready = (fstate == RUN) && (q_tag.size() < DEPTH);
    check_value("retire_valid_o", 32'(retire_valid_o), 32'(exp_valid));
    check_value("alloc_ready_o", 32'(alloc_ready_o), 32'(exp_ready));
    check_value("fence_done_o", 32'(fence_done_o), 32'(fstate == DONE));
    check_value("alloc_tag_o", 32'(alloc_tag_o), 32'(next_tag));
    if (exp_valid) begin
      check_value("retire_rd_o", 32'(retire_rd_o), 32'(q_rd[0]));
      check_value("retire_data_o", retire_data_o, q_data[0]);
    end
    if (rs1_addr_i == '0 || reg_known[rs1_addr_i]) begin
      check_value("rs1_data_o", rs1_data_o, (rs1_addr_i == '0) ? '0 : model_regs[rs1_addr_i]);
    end
    if (rs2_addr_i == '0 || reg_known[rs2_addr_i]) begin
      check_value("rs2_data_o", rs2_data_o, (rs2_addr_i == '0) ? '0 : model_regs[rs2_addr_i]);
    end
    if (fence_done_o) begin
      fence_done_cnt++;
    end
    chk_en     = 1'b0;
    case (fstate)
      RUN: begin
        if (fence_i) begin
          fstate = DRAIN;
          fence_req_cnt++;
        end
      end
      DRAIN:   fstate = (q_tag.size() == 0) ? DONE : DRAIN;
      default: fstate = RUN;
    endcase
    if (exp_valid && retire_ready_i) begin
      if (q_rd[0] != '0) begin
        model_regs[q_rd[0]] = q_data[0];
        reg_known[q_rd[0]]  = 1'b1;
      end
      chk_en         = 1'b1;
      chk_rd         = q_rd[0];
      done_m[q_tag[0]] = 1'b0;
      void'(q_tag.pop_front());
      void'(q_rd.pop_front());
      void'(q_data.pop_front());
    end
    if (exp_ready && alloc_valid_i) begin
      plan_data[next_tag] = $random(seed);
      done_m[next_tag]    = 1'b0;
      q_tag.push_back(next_tag);
      q_rd.push_back(alloc_rd_i);
      q_data.push_back(plan_data[next_tag]);
      pend.push_back(next_tag);
      next_tag = next_tag + rob_tag_t'(1);
    end
    if (cpl0_valid_i) done_m[cpl0_tag_i] = 1'b1;
    if (cpl1_valid_i) done_m[cpl1_tag_i] = 1'b1;
  endtask

  task automatic run_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      sample_outputs();
      @(posedge clk);
      #2;
      drive_inputs();
    end
  endtask

  task automatic drain_buffer();
    set_rates(0, 100, 100, 0);
    while (q_tag.size() > 0 || fstate != RUN) begin
      run_cycles(1);
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run hung after %0d cycles without finishing", cycle_cnt);
      $display("ERRORS FOUND");
      $fatal(1, "simulation timed out");
    end
  end

  initial begin
    alloc_valid_i  = 1'b0;
    alloc_rd_i     = '0;
    cpl0_valid_i   = 1'b0;
    cpl0_tag_i     = '0;
    cpl0_data_i    = '0;
    cpl1_valid_i   = 1'b0;
    cpl1_tag_i     = '0;
    cpl1_data_i    = '0;
    retire_ready_i = 1'b0;
    fence_i        = 1'b0;
    rs1_addr_i     = '0;
    rs2_addr_i     = '0;
    for (int i = 0; i < DEPTH; i++) done_m[i] = 1'b0;
    for (int i = 0; i < 32; i++) reg_known[i] = 1'b0;
    next_tag       = '0;
    fstate         = RUN;
    chk_en         = 1'b0;
    fence_req_cnt  = 0;
    fence_done_cnt = 0;
    @(posedge resetn);
    @(negedge clk);
    check_value("retire_valid_o after reset", 32'(retire_valid_o), 32'd0);
    check_value("fence_done_o after reset", 32'(fence_done_o), 32'd0);
    check_value("alloc_ready_o after reset", 32'(alloc_ready_o), 32'd1);
    @(posedge clk);
    #2;
    set_rates(70, 80, 75, 0);
    drive_inputs();
    run_cycles(RAND_CYCLES);
    // hold retirement off until the buffer fills
    set_rates(100, 0, 90, 0);
    run_cycles(BP_CYCLES);
    check_value("occupancy under back-pressure", 32'(q_tag.size()), 32'(DEPTH));
    check_value("alloc_ready_o when full", 32'(alloc_ready_o), 32'd0);
    drain_buffer();
    set_rates(60, 70, 70, 30);
    run_cycles(FENCE_CYCLES);
    drain_buffer();
    run_cycles(4);
    if (fence_req_cnt == 0) begin
      $display("no fence request was issued during the run");
      $display("ERRORS FOUND");
      $fatal(1, "fence path not exercised");
    end
    check_value("fence_done_o pulse count", 32'(fence_done_cnt), 32'(fence_req_cnt));
    $display("NO ERRORS");
    $finish;
  end

endmodule
